// ==== logic/csr_pkg.sv ====
// widths, csr addresses and encodings for the csr subsystem; misa is fixed at rv32i
package csr_pkg;

  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;
  localparam int order_w    = 64;

  localparam logic [6:0] opcode_system = 7'b1110011;

  // funct3 of the six zicsr operations
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  localparam logic [csr_addr_w-1:0] csr_mstatus       = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_misa          = 12'h301;
  localparam logic [csr_addr_w-1:0] csr_mtvec         = 12'h305;
  // scratch registers are contiguous from here
  localparam logic [csr_addr_w-1:0] csr_mscratch_base = 12'h340;

  // mxl of 1 and the i extension bit
  localparam logic [xlen-1:0] misa_value = 32'h4000_0100;

endpackage

// ==== logic/gpr_file.sv ====
// x0 always reads zero; a write on rd is visible to rs1 in the same cycle
`timescale 1ns/1ps

module gpr_file import csr_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1_addr,
  output logic [xlen-1:0] rs1_data,
  input  logic            rd_wr,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] rd_data
);

  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (rd_wr && rd != 5'd0)
      regs[rd] <= rd_data;
  end

  // the retiring write is forwarded so a dependent capture on that edge sees it
  always_comb
  begin
    if (rs1_addr == 5'd0)
      rs1_data = '0;
    else if (rd_wr && rd == rs1_addr)
      rs1_data = rd_data;
    else
      rs1_data = regs[rs1_addr];
  end

endmodule

// ==== logic/csr_dispatch.sv ====
// holds one instruction; only zicsr encodings raise a flag, all else is left to trap in exec
`timescale 1ns/1ps

module csr_dispatch import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_vld,
  input  logic [31:0]           fetch_inst,
  input  logic [xlen-1:0]       fetch_pc,
  output logic                  fetch_stall,
  input  logic                  exec_busy,
  input  logic                  exec_retired,
  output logic [4:0]            rs1_addr,
  input  logic [xlen-1:0]       rs1_data,
  output logic                  dpu_vld,
  output logic [31:0]           dpu_inst,
  output logic [order_w-1:0]    dpu_order,
  output logic [xlen-1:0]       dpu_pc,
  output logic [csr_addr_w-1:0] dpu_csr,
  output logic [4:0]            dpu_uimm,
  output logic [4:0]            dpu_rs1,
  output logic [4:0]            dpu_rd,
  output logic                  dpu_csrrw,
  output logic                  dpu_csrrs,
  output logic                  dpu_csrrc,
  output logic                  dpu_csrrwi,
  output logic                  dpu_csrrsi,
  output logic                  dpu_csrrci,
  output logic [xlen-1:0]       dpu_rs1_data
);

  logic               take;
  logic               load;
  logic               is_system;
  logic [2:0]         funct3;
  logic [order_w-1:0] order_cnt;

  // exec takes the held instruction when idle or retiring on this edge
  assign take        = dpu_vld & (~exec_busy | exec_retired);
  assign fetch_stall = dpu_vld & ~take;
  assign load        = fetch_vld & ~fetch_stall;

  assign is_system = fetch_inst[6:0] == opcode_system;
  assign funct3    = fetch_inst[14:12];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dpu_vld   <= 1'b0;
      order_cnt <= '0;
    end
    else if (load)
    begin
      dpu_vld   <= 1'b1;
      order_cnt <= order_cnt + order_w'(1);
    end
    else if (take)
      dpu_vld <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      dpu_inst   <= fetch_inst;
      dpu_order  <= order_cnt;
      dpu_pc     <= fetch_pc;
      dpu_csr    <= fetch_inst[31:20];
      dpu_uimm   <= fetch_inst[19:15];
      dpu_rs1    <= fetch_inst[19:15];
      dpu_rd     <= fetch_inst[11:7];
      dpu_csrrw  <= is_system && funct3 == f3_csrrw;
      dpu_csrrs  <= is_system && funct3 == f3_csrrs;
      dpu_csrrc  <= is_system && funct3 == f3_csrrc;
      dpu_csrrwi <= is_system && funct3 == f3_csrrwi;
      dpu_csrrsi <= is_system && funct3 == f3_csrrsi;
      dpu_csrrci <= is_system && funct3 == f3_csrrci;
    end
  end

  // operand follows the register file, including its write bypass
  assign rs1_addr     = dpu_rs1;
  assign dpu_rs1_data = rs1_data;

endmodule

// ==== logic/csr_exec.sv ====
// fixed issue/wait/complete sequence; assumes the csr file returns old data one cycle after req
`timescale 1ns/1ps

module csr_exec import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dpu_vld,
  input  logic [31:0]           dpu_inst,
  input  logic [order_w-1:0]    dpu_order,
  input  logic [xlen-1:0]       dpu_pc,
  input  logic [csr_addr_w-1:0] dpu_csr,
  input  logic [4:0]            dpu_uimm,
  input  logic [4:0]            dpu_rs1,
  input  logic [4:0]            dpu_rd,
  input  logic                  dpu_csrrw,
  input  logic                  dpu_csrrs,
  input  logic                  dpu_csrrc,
  input  logic                  dpu_csrrwi,
  input  logic                  dpu_csrrsi,
  input  logic                  dpu_csrrci,
  input  logic [xlen-1:0]       dpu_rs1_data,
  output logic                  exec_busy,
  output logic                  exec_retired,
  output logic                  csr_req,
  output logic                  csr_write,
  output logic [csr_addr_w-1:0] csr_addr,
  output logic [xlen-1:0]       csr_mask,
  output logic [xlen-1:0]       csr_data_wr,
  input  logic [xlen-1:0]       csr_data_rd,
  output logic                  retire_vld,
  output logic [order_w-1:0]    retire_order,
  output logic [xlen-1:0]       retire_pc,
  output logic [xlen-1:0]       retire_pc_next,
  output logic                  retire_trap,
  output logic                  retire_rd_wr,
  output logic [4:0]            retire_rd,
  output logic [xlen-1:0]       retire_rd_data
);

  logic                  ex_vld;
  logic [1:0]            step;
  logic [31:0]           ex_inst;
  logic [order_w-1:0]    ex_order;
  logic [xlen-1:0]       ex_pc;
  logic [csr_addr_w-1:0] ex_csr;
  logic [4:0]            ex_uimm;
  logic [4:0]            ex_rs1;
  logic [4:0]            ex_rd;
  logic                  ex_csrrw;
  logic                  ex_csrrs;
  logic                  ex_csrrc;
  logic                  ex_csrrwi;
  logic                  ex_csrrsi;
  logic                  ex_csrrci;
  logic [xlen-1:0]       ex_rs1_data;

  logic            take;
  logic            running;
  logic            is_csr;
  logic            trap_now;
  logic            retire_now;
  logic            imm_form;
  logic [xlen-1:0] operand;
  logic            op_nonzero;
  logic            wr_en;
  logic [xlen-1:0] wr_mask;
  logic [xlen-1:0] wr_data;

  assign exec_busy    = ex_vld;
  assign exec_retired = retire_vld;

  assign take    = dpu_vld & (~ex_vld | retire_vld);
  assign running = ex_vld & ~retire_vld;

  assign is_csr   = (ex_inst[6:0] == opcode_system) &
                    (ex_csrrw | ex_csrrs | ex_csrrc | ex_csrrwi | ex_csrrsi | ex_csrrci);
  assign trap_now = ~is_csr | (ex_pc[1:0] != 2'b00);

  // traps finish on the first cycle, csr operations on step 2
  assign retire_now = running & (trap_now | step == 2'd2);

  assign imm_form   = ex_csrrwi | ex_csrrsi | ex_csrrci;
  assign operand    = imm_form ? {{(xlen-5){1'b0}}, ex_uimm} : ex_rs1_data;
  // uimm and rs1 are the same instruction field, so one test serves both forms
  assign op_nonzero = ex_rs1 != 5'd0;

  // set and clear only touch the operand bits and skip the write for a zero source
  always_comb
  begin
    if (ex_csrrw | ex_csrrwi)
    begin
      wr_en   = 1'b1;
      wr_mask = '1;
      wr_data = operand;
    end
    else if (ex_csrrs | ex_csrrsi)
    begin
      wr_en   = op_nonzero;
      wr_mask = operand;
      wr_data = '1;
    end
    else
    begin
      wr_en   = op_nonzero;
      wr_mask = operand;
      wr_data = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ex_vld       <= 1'b0;
      step         <= 2'd0;
      csr_req      <= 1'b0;
      retire_vld   <= 1'b0;
      retire_trap  <= 1'b0;
      retire_rd_wr <= 1'b0;
    end
    else
    begin
      csr_req      <= 1'b0;
      retire_vld   <= retire_now;
      retire_trap  <= retire_now & trap_now;
      retire_rd_wr <= retire_now & ~trap_now;
      if (take)
      begin
        ex_vld <= 1'b1;
        step   <= 2'd0;
      end
      else if (retire_vld)
        ex_vld <= 1'b0;
      if (running && !trap_now)
      begin
        case (step)
          2'd0:
          begin
            csr_req <= 1'b1;
            step    <= 2'd1;
          end
          2'd1: step <= 2'd2;
          default: step <= 2'd0;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      ex_inst     <= dpu_inst;
      ex_order    <= dpu_order;
      ex_pc       <= dpu_pc;
      ex_csr      <= dpu_csr;
      ex_uimm     <= dpu_uimm;
      ex_rs1      <= dpu_rs1;
      ex_rd       <= dpu_rd;
      ex_csrrw    <= dpu_csrrw;
      ex_csrrs    <= dpu_csrrs;
      ex_csrrc    <= dpu_csrrc;
      ex_csrrwi   <= dpu_csrrwi;
      ex_csrrsi   <= dpu_csrrsi;
      ex_csrrci   <= dpu_csrrci;
      ex_rs1_data <= dpu_rs1_data;
    end
    if (running && !trap_now && step == 2'd0)
    begin
      csr_write   <= wr_en;
      csr_addr    <= ex_csr;
      csr_mask    <= wr_mask;
      csr_data_wr <= wr_data;
    end
    if (retire_now)
    begin
      retire_order   <= ex_order;
      retire_pc      <= ex_pc;
      retire_pc_next <= ex_pc + xlen'(4);
      retire_rd      <= ex_rd;
      retire_rd_data <= (trap_now || ex_rd == 5'd0) ? '0 : csr_data_rd;
    end
  end

endmodule

// ==== logic/csr_file.sv ====
// unimplemented addresses read zero and drop writes; misa is constant
`timescale 1ns/1ps

module csr_file import csr_pkg::*;
#(
  parameter int scratch_count = 4
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  csr_req,
  input  logic                  csr_write,
  input  logic [csr_addr_w-1:0] csr_addr,
  input  logic [xlen-1:0]       csr_mask,
  input  logic [xlen-1:0]       csr_data_wr,
  output logic [xlen-1:0]       csr_data_rd
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] scratch [scratch_count];
  logic [xlen-1:0] old_value;
  logic [xlen-1:0] new_value;

  always_comb
  begin
    old_value = '0;
    case (csr_addr)
      csr_mstatus: old_value = mstatus;
      csr_mtvec:   old_value = mtvec;
      csr_misa:    old_value = misa_value;
      default:
      begin
        for (int i = 0; i < scratch_count; i++)
          if (csr_addr == csr_mscratch_base + csr_addr_w'(i))
            old_value = scratch[i];
      end
    endcase
  end

  // masked bits take the write data, the rest keep their old value
  assign new_value = (old_value & ~csr_mask) | (csr_data_wr & csr_mask);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mstatus <= '0;
      mtvec   <= '0;
      for (int i = 0; i < scratch_count; i++)
        scratch[i] <= '0;
    end
    else if (csr_req && csr_write)
    begin
      if (csr_addr == csr_mstatus)
        mstatus <= new_value;
      if (csr_addr == csr_mtvec)
        mtvec <= new_value;
      for (int i = 0; i < scratch_count; i++)
        if (csr_addr == csr_mscratch_base + csr_addr_w'(i))
          scratch[i] <= new_value;
    end
  end

  // the value before the write is returned and held until the next request
  always_ff @(posedge clk)
  begin
    if (csr_req)
      csr_data_rd <= old_value;
  end

endmodule

// ==== logic/csr_core.sv ====
// one instruction in dispatch and one in exec at most; fetch must hold while fetch_stall is high
`timescale 1ns/1ps

module csr_core import csr_pkg::*;
#(
  parameter int scratch_count = 4
)
(
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_vld,
  input  logic [31:0]        fetch_inst,
  input  logic [xlen-1:0]    fetch_pc,
  output logic               fetch_stall,
  output logic               retire_vld,
  output logic [order_w-1:0] retire_order,
  output logic [xlen-1:0]    retire_pc,
  output logic [xlen-1:0]    retire_pc_next,
  output logic               retire_trap,
  output logic               retire_rd_wr,
  output logic [4:0]         retire_rd,
  output logic [xlen-1:0]    retire_rd_data
);

  logic                  exec_busy;
  logic                  exec_retired;
  logic [4:0]            rs1_addr;
  logic [xlen-1:0]       rs1_data;
  logic                  dpu_vld;
  logic [31:0]           dpu_inst;
  logic [order_w-1:0]    dpu_order;
  logic [xlen-1:0]       dpu_pc;
  logic [csr_addr_w-1:0] dpu_csr;
  logic [4:0]            dpu_uimm;
  logic [4:0]            dpu_rs1;
  logic [4:0]            dpu_rd;
  logic                  dpu_csrrw;
  logic                  dpu_csrrs;
  logic                  dpu_csrrc;
  logic                  dpu_csrrwi;
  logic                  dpu_csrrsi;
  logic                  dpu_csrrci;
  logic [xlen-1:0]       dpu_rs1_data;
  logic                  csr_req;
  logic                  csr_write;
  logic [csr_addr_w-1:0] csr_addr;
  logic [xlen-1:0]       csr_mask;
  logic [xlen-1:0]       csr_data_wr;
  logic [xlen-1:0]       csr_data_rd;

  csr_dispatch u_dispatch (
    .clk, .rst, .fetch_vld, .fetch_inst, .fetch_pc, .fetch_stall,
    .exec_busy, .exec_retired, .rs1_addr, .rs1_data,
    .dpu_vld, .dpu_inst, .dpu_order, .dpu_pc, .dpu_csr, .dpu_uimm, .dpu_rs1, .dpu_rd,
    .dpu_csrrw, .dpu_csrrs, .dpu_csrrc, .dpu_csrrwi, .dpu_csrrsi, .dpu_csrrci,
    .dpu_rs1_data
  );

  // the register file is written straight from the retire record
  gpr_file u_gpr (
    .clk, .rst, .rs1_addr, .rs1_data,
    .rd_wr   (retire_rd_wr),
    .rd      (retire_rd),
    .rd_data (retire_rd_data)
  );

  csr_exec u_exec (
    .clk, .rst,
    .dpu_vld, .dpu_inst, .dpu_order, .dpu_pc, .dpu_csr, .dpu_uimm, .dpu_rs1, .dpu_rd,
    .dpu_csrrw, .dpu_csrrs, .dpu_csrrc, .dpu_csrrwi, .dpu_csrrsi, .dpu_csrrci,
    .dpu_rs1_data, .exec_busy, .exec_retired,
    .csr_req, .csr_write, .csr_addr, .csr_mask, .csr_data_wr, .csr_data_rd,
    .retire_vld, .retire_order, .retire_pc, .retire_pc_next, .retire_trap,
    .retire_rd_wr, .retire_rd, .retire_rd_data
  );

  csr_file #(
    .scratch_count (scratch_count)
  ) u_csr (
    .clk, .rst, .csr_req, .csr_write, .csr_addr, .csr_mask, .csr_data_wr, .csr_data_rd
  );

endmodule

// ==== bench/csr_core_properties.sv ====
// bound into csr_exec; checks strobe shapes only, the data is compared by the checker
`timescale 1ns/1ps

module csr_core_properties
(
  input logic clk,
  input logic rst,
  input logic csr_req,
  input logic retire_vld,
  input logic retire_trap,
  input logic retire_rd_wr
);

  int assert_fails = 0;

  req_single: assert property (@(posedge clk) disable iff (rst) csr_req |=> !csr_req)
    else
    begin
      $error("csr_req stayed high for more than one cycle");
      assert_fails++;
    end

  retire_single: assert property (@(posedge clk) disable iff (rst) retire_vld |=> !retire_vld)
    else
    begin
      $error("retire_vld asserted on two consecutive cycles");
      assert_fails++;
    end

  // a trapped instruction must never write the register file
  trap_no_write: assert property (@(posedge clk) disable iff (rst) !(retire_rd_wr && retire_trap))
    else
    begin
      $error("retire_rd_wr asserted together with retire_trap");
      assert_fails++;
    end

endmodule

bind csr_exec csr_core_properties u_props (
  .clk, .rst, .csr_req, .retire_vld, .retire_trap, .retire_rd_wr
);

// ==== bench/csr_core_checker.sv ====
// reference model of the zicsr rules; scratch range is taken from u_dut, misa from csr_pkg
`timescale 1ns/1ps

module csr_core_checker import csr_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_vld,
  input  logic [31:0]        fetch_inst,
  input  logic [xlen-1:0]    fetch_pc,
  input  logic               fetch_stall,
  input  logic               exp_trap,
  input  logic [xlen-1:0]    exp_rd_data,
  input  logic               retire_vld,
  input  logic [order_w-1:0] retire_order,
  input  logic [xlen-1:0]    retire_pc,
  input  logic [xlen-1:0]    retire_pc_next,
  input  logic               retire_trap,
  input  logic               retire_rd_wr,
  input  logic [4:0]         retire_rd,
  input  logic [xlen-1:0]    retire_rd_data,
  output int                 check_count,
  output int                 fail_count
);

  typedef struct packed {
    logic [order_w-1:0] order;
    logic [xlen-1:0]    pc;
    logic               trap;
    logic [4:0]         rd;
    logic [xlen-1:0]    rd_data;
    logic               bad;
    logic [31:0]        born;
  } pending_t;

  // longest wait is one instruction ahead in exec plus its own sequence
  localparam int retire_limit = 16;

  logic [xlen-1:0] gpr_model [32];
  logic [xlen-1:0] csr_model [4096];
  pending_t        pending [$];
  pending_t        ent;
  logic [63:0]     accepted;
  logic [31:0]     cycle;
  logic            field_bad;
  int              test_idx;
  int              scratch_n;
  logic            m_trap;
  logic [xlen-1:0] m_rd_data;

  initial scratch_n = csr_core_tb.u_dut.scratch_count;

  function automatic logic csr_known(input logic [csr_addr_w-1:0] addr);
    int offset;
    offset = int'(addr) - int'(csr_mscratch_base);
    return addr == csr_mstatus || addr == csr_mtvec || (offset >= 0 && offset < scratch_n);
  endfunction

  function automatic logic [xlen-1:0] csr_peek(input logic [csr_addr_w-1:0] addr);
    if (addr == csr_misa)
      return misa_value;
    else if (csr_known(addr))
      return csr_model[addr];
    return '0;
  endfunction

  // applies one instruction to the model in program order
  task automatic model_step(input logic [31:0] inst, input logic [xlen-1:0] pc,
                            output logic trap, output logic [xlen-1:0] rd_val);
    logic [2:0]            f3;
    logic [csr_addr_w-1:0] addr;
    logic [4:0]            src;
    logic [4:0]            dst;
    logic [xlen-1:0]       old;
    logic [xlen-1:0]       opnd;
    f3     = inst[14:12];
    addr   = inst[31:20];
    src    = inst[19:15];
    dst    = inst[11:7];
    trap   = inst[6:0] != opcode_system || f3 == 3'b000 || f3 == 3'b100 || pc[1:0] != 2'b00;
    rd_val = '0;
    if (!trap)
    begin
      old  = csr_peek(addr);
      opnd = f3[2] ? {{(xlen-5){1'b0}}, src} : gpr_model[src];
      if (csr_known(addr))
      begin
        if (f3[1:0] == 2'b01)
          csr_model[addr] = opnd;
        else if (f3[1:0] == 2'b10 && src != 5'd0)
          csr_model[addr] = old | opnd;
        else if (f3[1:0] == 2'b11 && src != 5'd0)
          csr_model[addr] = old & ~opnd;
      end
      if (dst != 5'd0)
      begin
        rd_val         = old;
        gpr_model[dst] = old;
      end
    end
  endtask

  task automatic compare_field(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("MISMATCH at %0t ns: test %0d %s expected %0h got %0h",
               $time, test_idx, field, expected, actual);
      field_bad = 1'b1;
    end
  endtask

  task automatic report_test(input pending_t e);
    check_count++;
    if (field_bad)
      fail_count++;
    $display("test %0d pc %08h %s %s", test_idx, e.pc, e.trap ? "trap" : "csr",
             field_bad ? "fail" : "ok");
  endtask

  task automatic accept_fetch();
    model_step(fetch_inst, fetch_pc, m_trap, m_rd_data);
    ent.order   = accepted;
    ent.pc      = fetch_pc;
    ent.trap    = m_trap;
    ent.rd      = fetch_inst[11:7];
    ent.rd_data = m_rd_data;
    ent.born    = cycle;
    ent.bad     = 1'b0;
    if (m_trap !== exp_trap || m_rd_data !== exp_rd_data)
    begin
      $display("MISMATCH at %0t ns: test %0d stimulus gives trap %0b rd %08h, model %0b rd %08h",
               $time, accepted, exp_trap, exp_rd_data, m_trap, m_rd_data);
      ent.bad = 1'b1;
    end
    pending.push_back(ent);
    accepted = accepted + 64'd1;
  endtask

  task automatic check_retire();
    if (pending.size() == 0)
    begin
      $display("retire at %0t ns arrived with no instruction outstanding", $time);
      fail_count++;
    end
    else
    begin
      ent       = pending.pop_front();
      test_idx  = int'(ent.order);
      field_bad = ent.bad;
      compare_field("retire_order", 64'(ent.order), 64'(retire_order));
      compare_field("retire_pc", 64'(ent.pc), 64'(retire_pc));
      compare_field("retire_trap", 64'(ent.trap), 64'(retire_trap));
      compare_field("retire_rd_wr", 64'(!ent.trap), 64'(retire_rd_wr));
      if (!ent.trap)
      begin
        compare_field("retire_pc_next", 64'(ent.pc + 32'd4), 64'(retire_pc_next));
        compare_field("retire_rd", 64'(ent.rd), 64'(retire_rd));
        compare_field("retire_rd_data", 64'(ent.rd_data), 64'(retire_rd_data));
      end
      report_test(ent);
    end
  endtask

  task automatic drop_missing();
    ent       = pending.pop_front();
    test_idx  = int'(ent.order);
    field_bad = 1'b1;
    $display("test %0d at pc %08h was accepted but never retired", test_idx, ent.pc);
    report_test(ent);
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        gpr_model[i] = '0;
      for (int i = 0; i < 4096; i++)
        csr_model[i] = '0;
      pending.delete();
      accepted    = '0;
      cycle       = '0;
      check_count = 0;
      fail_count  = 0;
    end
    else
    begin
      cycle = cycle + 32'd1;
      if (retire_vld)
        check_retire();
      else if (pending.size() > 0 && cycle - pending[0].born > retire_limit)
        drop_missing();
      if (fetch_vld && !fetch_stall)
        accept_fetch();
    end
  end

endmodule

// ==== bench/csr_core_tb.sv ====
// stimulus comes from bench/csr_stimulus.txt, read relative to the project root
`timescale 1ns/1ps

module csr_core_tb import csr_pkg::*; ();

  localparam int max_tests    = 64;
  localparam int reset_cycles = 4;

  logic               clk;
  logic               rst;
  logic               fetch_vld;
  logic [31:0]        fetch_inst;
  logic [xlen-1:0]    fetch_pc;
  logic               fetch_stall;
  logic               retire_vld;
  logic [order_w-1:0] retire_order;
  logic [xlen-1:0]    retire_pc;
  logic [xlen-1:0]    retire_pc_next;
  logic               retire_trap;
  logic               retire_rd_wr;
  logic [4:0]         retire_rd;
  logic [xlen-1:0]    retire_rd_data;
  logic               exp_trap;
  logic [xlen-1:0]    exp_rd_data;
  int                 check_count;
  int                 fail_count;
  logic [31:0]        stim_mem [0:4*max_tests];
  int                 n_tests;
  logic               loaded;

  csr_core #(
    .scratch_count (4)
  ) u_dut (
    .clk, .rst, .fetch_vld, .fetch_inst, .fetch_pc, .fetch_stall,
    .retire_vld, .retire_order, .retire_pc, .retire_pc_next, .retire_trap,
    .retire_rd_wr, .retire_rd, .retire_rd_data
  );

  csr_core_checker u_checker (
    .clk, .rst, .fetch_vld, .fetch_inst, .fetch_pc, .fetch_stall, .exp_trap, .exp_rd_data,
    .retire_vld, .retire_order, .retire_pc, .retire_pc_next, .retire_trap,
    .retire_rd_wr, .retire_rd, .retire_rd_data, .check_count, .fail_count
  );

  always #50 clk = ~clk;

  // offers one instruction after a random idle gap and returns once it is captured
  task automatic send_one(input int idx);
    int gap;
    gap       = $urandom_range(3, 0);
    fetch_vld = 1'b0;
    repeat (gap)
    begin
      @(posedge clk);
      #1;
    end
    while (fetch_stall)
    begin
      @(posedge clk);
      #1;
    end
    fetch_inst  = stim_mem[1 + 4 * idx];
    fetch_pc    = stim_mem[2 + 4 * idx];
    exp_trap    = stim_mem[3 + 4 * idx][0];
    exp_rd_data = stim_mem[4 + 4 * idx];
    fetch_vld   = 1'b1;
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    int errors;
    logic file_ok;
    clk         = 1'b0;
    rst         = 1'b1;
    fetch_vld   = 1'b0;
    fetch_inst  = '0;
    fetch_pc    = '0;
    exp_trap    = 1'b0;
    exp_rd_data = '0;
    loaded      = 1'b0;
    void'($urandom(32'hb5af_96f8));
    $readmemh("bench/csr_stimulus.txt", stim_mem);
    n_tests = int'(stim_mem[0]);
    file_ok = n_tests > 0 && n_tests <= max_tests;
    if (!file_ok)
    begin
      $display("stimulus file gives an unusable instruction count of %0d", n_tests);
      n_tests = 0;
    end
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_tests; i++)
      send_one(i);
    fetch_vld = 1'b0;
    while (check_count < n_tests)
      @(posedge clk);
    repeat (2) @(posedge clk);
    errors = fail_count + u_dut.u_exec.u_props.assert_fails + (file_ok ? 0 : 1);
    $display("closing: %0d tests, %0d checked, %0d failed, %0d assertion failures",
             n_tests, check_count, fail_count, u_dut.u_exec.u_props.assert_fails);
    if (errors == 0 && check_count == n_tests)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // allows eight cycles per instruction on top of reset
  initial
  begin
    wait (loaded);
    repeat (n_tests * 8 + reset_cycles) @(posedge clk);
    $display("timeout: only %0d of %0d tests finished in time", check_count, n_tests);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== bench/csr_stimulus.txt ====
// first word is the instruction count; each row after it is
// fetch_inst fetch_pc expected_trap expected_rd_data, all in hex
00000011
340AD0F3 00001000 0 00000000
34002173 00001004 0 00000015
305111F3 00001008 0 00000000
30502273 0000100C 0 00000015
300552F3 00001010 0 00000000
30012373 00001014 0 0000000A
300333F3 00001018 0 0000001F
30007473 0000101C 0 00000015
300464F3 00001020 0 00000015
30003573 00001024 0 0000001D
301115F3 00001028 0 40000100
30102673 0000102C 0 40000100
7C0116F3 00001030 0 00000000
34059073 00001034 0 00000000
00500093 00001038 1 00000000
340FD773 0000103E 1 00000000
340027F3 00001040 0 40000100

// ==== csr_core.f ====
logic/csr_pkg.sv
logic/gpr_file.sv
logic/csr_dispatch.sv
logic/csr_exec.sv
logic/csr_file.sv
logic/csr_core.sv
bench/csr_core_properties.sv
bench/csr_core_checker.sv
bench/csr_core_tb.sv

// ==== Makefile ====
TOP := csr_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f csr_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f csr_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir
